//--- idct2d.f
+incdir+.
idctTypesPkg.sv
idctCoefPkg.sv
idctMac.sv
idctPass.sv
idct2d.sv
idct2d_assert.sv
idct2d_tb.sv

//--- idct2d.sv
// ---------------------------------------------------------------------
// 8x8 inverse DCT top level, row pass followed by column pass
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module idct2d
   import idctTypesPkg::*;
#(
   parameter int RowShift = 15,
   parameter int ColShift = 18
)
(
   input  logic     clk,
   input  logic     racc,
   input  logic     inValid,
   output logic     inReady,
   input  sampleT   inSample,
   output logic     outValid,
   input  logic     outReady,
   output wordBeatT outBeat
);

   wordT inWord;

   // transposed row results on their way to the column pass
   logic     midValid;
   logic     midReady;
   wordBeatT midBeat;

   // sign extension to the datapath width
   assign inWord = wordT'(inSample);

   idctPass #(
      .ResultShift(RowShift)
   ) rowPass (
      .clk     (clk),
      .racc    (racc),
      .inValid (inValid),
      .inReady (inReady),
      .inWord  (inWord),
      .outValid(midValid),
      .outReady(midReady),
      .outBeat (midBeat)
   );

   // column pass counts its own positions, only the value is passed on
   idctPass #(
      .ResultShift(ColShift)
   ) colPass (
      .clk     (clk),
      .racc    (racc),
      .inValid (midValid),
      .inReady (midReady),
      .inWord  (midBeat.value),
      .outValid(outValid),
      .outReady(outReady),
      .outBeat (outBeat)
   );

endmodule

`default_nettype wire

//--- idct2d_assert.sv
// ---------------------------------------------------------------------
// concurrent checks on the output stream of the 8x8 IDCT top level
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module idct2d_assert
   import idctTypesPkg::*;
(
   input logic     clk,
   input logic     racc,
   input logic     outValid,
   input logic     outReady,
   input wordBeatT outBeat
);

   // accepted output beats within the current block
   countT beatCount;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         beatCount <= '0;
      end
      else if (outValid && outReady)
      begin
         beatCount <= beatCount + countT'(1);
      end
   end

   resetQuiet: assert property (@(posedge clk) racc |-> !outValid)
      else $error("outValid was high during reset");

   holdStable: assert property (@(posedge clk) disable iff (racc)
      outValid && !outReady |=> outValid && $stable(outBeat))
      else $error("held output beat changed before it was taken");

   // a block ends exactly at position 63
   nextBlockStart: assert property (@(posedge clk) disable iff (racc)
      outValid && outReady && outBeat.last |=> beatCount == '0)
      else $error("beat after a last flag was not the start of a block");

endmodule

bind idct2d idct2d_assert outputChecks (
   .clk     (clk),
   .racc    (racc),
   .outValid(outValid),
   .outReady(outReady),
   .outBeat (outBeat)
);

`default_nettype wire

//--- idct2d_model.svh
// ---------------------------------------------------------------------
// reference model of the fixed-point 8x8 inverse DCT
// row transform, transpose, column transform, pixels row-major
// ---------------------------------------------------------------------
`ifndef IDCT2D_MODEL_SVH
`define IDCT2D_MODEL_SVH

localparam int ModelRowShift = 15;
localparam int ModelColShift = 18;

task automatic referenceBlock(input sampleT coefs [64], output wordT pixels [64]);
   wordT rowOut [8][8];
   accT sum;
   // rowOut[k][x] is row k of the input transformed at position x
   for (int k = 0; k < 8; k++)
   begin
      for (int x = 0; x < 8; x++)
      begin
         sum = '0;
         for (int m = 0; m < 8; m++)
         begin
            sum += accT'(coefs[k * 8 + m]) * accT'(cosTable[x][m]);
         end
         rowOut[k][x] = wordT'(sum >>> ModelRowShift);
      end
   end
   // column transform, y outer and x inner
   for (int y = 0; y < 8; y++)
   begin
      for (int x = 0; x < 8; x++)
      begin
         sum = '0;
         for (int k = 0; k < 8; k++)
         begin
            sum += accT'(rowOut[k][x]) * accT'(cosTable[y][k]);
         end
         pixels[y * 8 + x] = wordT'(sum >>> ModelColShift);
      end
   end
endtask

`endif

//--- idct2d_tb.sv
// ---------------------------------------------------------------------
// directed testbench for the 8x8 inverse DCT top level
// stimulus and collection tasks, compare tasks, timeout
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module idct2d_tb
   import idctTypesPkg::*, idctCoefPkg::*;
;

   `include "idct2d_model.svh"

   // generous bound per block that covers random stalls
   localparam int BlocksSent = 8;
   localparam int CycleLimit = 2000 * BlocksSent + 200;

   logic     clk = 1'b0;
   logic     racc;
   logic     inValid;
   logic     inReady;
   sampleT   inSample;
   logic     outValid;
   logic     outReady;
   wordBeatT outBeat;

   logic [31:0] rngState;
   int          cycleCount = 0;

   sampleT blockIn [64];
   wordT   blockRef [64];
   sampleT stimQ [$];
   wordT   expectQ [$];
   sampleT savedQ [$];

   idct2d #(
      .RowShift(ModelRowShift),
      .ColShift(ModelColShift)
   ) DUT (
      .clk     (clk),
      .racc    (racc),
      .inValid (inValid),
      .inReady (inReady),
      .inSample(inSample),
      .outValid(outValid),
      .outReady(outReady),
      .outBeat (outBeat)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] nextRandom();
      logic [31:0] s;
      s = rngState;
      s ^= s << 13;
      s ^= s >> 17;
      s ^= s << 5;
      rngState = s;
      return s;
   endfunction

   function automatic logic takeGap(input int pct);
      return pct > 0 && int'(nextRandom() % 100) < pct;
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first failure");
   endtask

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit)
      begin
         failRun($sformatf("the run timed out after %0d cycles", cycleCount));
      end
   end

   task automatic comparePixel(input wordT got, input wordT expected, input int pos);
      if (got !== expected)
      begin
         failRun($sformatf("error at %0t: pixel %0d of block %0d is %0d, expected %0d",
            $time, pos % 64, pos / 64, got, expected));
      end
   endtask

   task automatic compareLast(input logic got, input logic expected, input int pos);
      if (got !== expected)
      begin
         failRun($sformatf("error at %0t: last flag of pixel %0d of block %0d is %b",
            $time, pos % 64, pos / 64, got));
      end
   endtask

   task automatic queueBlock();
      referenceBlock(blockIn, blockRef);
      for (int i = 0; i < 64; i++)
      begin
         stimQ.push_back(blockIn[i]);
         expectQ.push_back(blockRef[i]);
      end
   endtask

   // a pending beat is held until inReady takes it
   task automatic sendStream(input int gapPct);
      int   sent;
      logic pending;
      sent = 0;
      pending = 1'b0;
      while (sent < stimQ.size())
      begin
         @(negedge clk);
         if (!pending && takeGap(gapPct))
         begin
            inValid = 1'b0;
         end
         else
         begin
            inValid = 1'b1;
            inSample = stimQ[sent];
            pending = !inReady;
            if (inReady)
            begin
               sent++;
            end
         end
      end
      @(negedge clk);
      inValid = 1'b0;
   endtask

   task automatic collectStream(input int stallPct);
      int       taken;
      wordBeatT beat;
      taken = 0;
      while (taken < expectQ.size())
      begin
         @(negedge clk);
         outReady = !takeGap(stallPct);
         if (outValid && outReady)
         begin
            beat = outBeat;
            comparePixel(beat.value, expectQ[taken], taken);
            compareLast(beat.last, (taken % 64) == 63, taken);
            taken++;
         end
      end
      outReady = 1'b1;
   endtask

   task automatic runBlocks(input int gapPct, input int stallPct);
      fork
         sendStream(gapPct);
         collectStream(stallPct);
      join
      stimQ.delete();
      expectQ.delete();
   endtask

   task automatic fillRandom(input logic save);
      foreach (blockIn[i])
      begin
         blockIn[i] = sampleT'(nextRandom());
         if (save)
         begin
            savedQ.push_back(blockIn[i]);
         end
      end
   endtask

   task automatic checkResetState();
      if (outValid !== 1'b0 || inReady !== 1'b1)
      begin
         failRun("after reset outValid was not low or inReady was not high");
      end
   endtask

   task automatic transformDcBlock();
      foreach (blockIn[i])
      begin
         blockIn[i] = '0;
      end
      blockIn[0] = sampleT'(1000);
      queueBlock();
      runBlocks(0, 0);
   endtask

   task automatic transformRandomBlocks();
      repeat (2)
      begin
         fillRandom(1'b1);
         queueBlock();
      end
      runBlocks(0, 0);
   endtask

   task automatic streamBackToBack();
      repeat (3)
      begin
         fillRandom(1'b0);
         queueBlock();
      end
      runBlocks(0, 0);
   endtask

   // the random test's blocks again with gaps on both streams
   task automatic replayWithGaps();
      for (int b = 0; b < 2; b++)
      begin
         foreach (blockIn[i])
         begin
            blockIn[i] = savedQ[b * 64 + i];
         end
         queueBlock();
      end
      runBlocks(30, 40);
   endtask

   initial
   begin
      rngState = 32'hee8c_e1fa;
      racc = 1'b1;
      inValid = 1'b0;
      inSample = '0;
      outReady = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      racc = 1'b0;
      @(negedge clk);
      checkResetState();
      transformDcBlock();
      transformRandomBlocks();
      streamBackToBack();
      replayWithGaps();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- idctCoefPkg.sv
// ---------------------------------------------------------------------
// Q15 cosine factor type and the 8x8 IDCT basis table
// lookup helper indexed by spatial and frequency position
// ---------------------------------------------------------------------
`default_nettype none

package idctCoefPkg;

   import idctTypesPkg::*;

   localparam int CoefWidth = 16;

   typedef logic signed [CoefWidth-1:0] coefT;

   // entry [x][u] is cos((2x+1)*u*pi/16) in Q15
   // column u=0 carries the 1/sqrt(2) factor
   localparam coefT cosTable [8][8] = '{
      '{23170,  32138,  30274,  27246,  23170,  18205,  12540,   6393},
      '{23170,  27246,  12540,  -6393, -23170, -32138, -30274, -18205},
      '{23170,  18205, -12540, -32138, -23170,   6393,  30274,  27246},
      '{23170,   6393, -30274, -18205,  23170,  27246, -12540, -32138},
      '{23170,  -6393, -30274,  18205,  23170, -27246, -12540,  32138},
      '{23170, -18205, -12540,  32138, -23170,  -6393,  30274, -27246},
      '{23170, -27246,  12540,   6393, -23170,  32138, -30274,  18205},
      '{23170, -32138,  30274, -27246,  23170, -18205,  12540,  -6393}
   };

   // x is the spatial position, u the frequency
   function automatic coefT cosAt(input indexT x, input indexT u);
      return cosTable[x][u];
   endfunction

endpackage

`default_nettype wire

//--- idctMac.sv
// ---------------------------------------------------------------------
// two-stage signed multiply-accumulate for one transform pass
// stage one multiplies, stage two sums and emits the shifted result
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module idctMac
   import idctTypesPkg::*, idctCoefPkg::*;
#(
   parameter int ResultShift = 15
)
(
   input  logic clk,
   input  logic racc,
   input  logic termValid,
   input  logic termFirst,
   input  logic termLast,
   input  wordT operand,
   input  coefT coef,
   output logic resultValid,
   output wordT result
);

   // product stage flags
   logic prodValid;
   logic prodFirst;
   logic prodLast;

   accT product;
   accT acc;
   accT sumNext;
   accT sumShifted;

   // a first term restarts the sum
   assign sumNext = prodFirst ? product : acc + product;

   assign sumShifted = sumNext >>> ResultShift;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         prodValid   <= 1'b0;
         prodFirst   <= 1'b0;
         prodLast    <= 1'b0;
         resultValid <= 1'b0;
      end
      else
      begin
         prodValid   <= termValid;
         prodFirst   <= termFirst;
         prodLast    <= termLast;
         // one-cycle pulse, two cycles after the last term
         resultValid <= prodValid && prodLast;
      end
   end

   always_ff @(posedge clk)
   begin
      if (termValid)
      begin
         product <= accT'(operand) * accT'(coef);
      end
      if (prodValid)
      begin
         acc <= sumNext;
         if (prodLast)
         begin
            result <= wordT'(sumShifted);
         end
      end
   end

endmodule

`default_nettype wire

//--- idctPass.sv
// ---------------------------------------------------------------------
// one 1-D IDCT stage with a 64-word block buffer and term sequencer
// results leave transposed, one held beat at a time
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module idctPass
   import idctTypesPkg::*, idctCoefPkg::*;
#(
   parameter int ResultShift = 15
)
(
   input  logic     clk,
   input  logic     racc,
   input  logic     inValid,
   output logic     inReady,
   input  wordT     inWord,
   output logic     outValid,
   input  logic     outReady,
   output wordBeatT outBeat
);

   typedef enum logic [1:0]
   {
      Load,
      Issue,
      WaitResult,
      HoldOutput
   } phaseT;

   phaseT phase;

   // write position while loading
   countT loadCount;

   // {b, a} of the result being worked on, b outer
   countT resultCount;

   // k of the term being issued
   indexT termCount;

   wordT blockBuf [64];

   indexT resA;
   indexT resB;

   // term stream into the MAC
   logic termValid;
   logic termFirst;
   logic termLast;
   wordT termOperand;
   coefT termCoef;

   logic macValid;
   wordT macResult;

   assign resA = resultCount[2:0];
   assign resB = resultCount[5:3];

   assign inReady  = (phase == Load);
   assign outValid = (phase == HoldOutput);

   // R[a][b] needs X[a][k] and cosTable[b][k] for k = 0..7
   assign termValid   = (phase == Issue);
   assign termFirst   = (termCount == 3'd0);
   assign termLast    = (termCount == 3'd7);
   assign termOperand = blockBuf[{resA, termCount}];
   assign termCoef    = cosAt(resB, termCount);

   idctMac #(
      .ResultShift(ResultShift)
   ) mac (
      .clk        (clk),
      .racc       (racc),
      .termValid  (termValid),
      .termFirst  (termFirst),
      .termLast   (termLast),
      .operand    (termOperand),
      .coef       (termCoef),
      .resultValid(macValid),
      .result     (macResult)
   );

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         phase       <= Load;
         loadCount   <= '0;
         resultCount <= '0;
         termCount   <= '0;
      end
      else
      begin
         case (phase)
            Load:
            begin
               if (inValid)
               begin
                  loadCount <= loadCount + countT'(1);
                  if (loadCount == 6'd63)
                  begin
                     phase <= Issue;
                  end
               end
            end
            Issue:
            begin
               // counter wraps back to 0 after the last term
               termCount <= termCount + indexT'(1);
               if (termLast)
               begin
                  phase <= WaitResult;
               end
            end
            WaitResult:
            begin
               if (macValid)
               begin
                  phase <= HoldOutput;
               end
            end
            HoldOutput:
            begin
               if (outReady)
               begin
                  resultCount <= resultCount + countT'(1);
                  if (outBeat.last)
                  begin
                     phase <= Load;
                  end
                  else
                  begin
                     phase <= Issue;
                  end
               end
            end
            default:
            begin
               phase <= Load;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (inValid && inReady)
      begin
         blockBuf[loadCount] <= inWord;
      end
      // MAC result is captured once and held until taken
      if (macValid)
      begin
         outBeat.value <= macResult;
         outBeat.last  <= (resultCount == 6'd63);
      end
   end

endmodule

`default_nettype wire

//--- idctTypesPkg.sv
// ---------------------------------------------------------------------
// datapath widths and the signed word types of the 8x8 inverse DCT
// stream beat struct shared by the two transform stages
// ---------------------------------------------------------------------
`default_nettype none

package idctTypesPkg;

   // input coefficients as they arrive on the block stream
   localparam int SampleWidth = 16;

   // every datapath word between and after the passes
   localparam int WordWidth = 24;

   // room for 8 products of a word and a Q15 factor
   localparam int AccWidth = 48;

   // row or column inside a block
   localparam int IndexWidth = 3;

   // position 0..63 inside a block
   localparam int CountWidth = 6;

   typedef logic signed [SampleWidth-1:0] sampleT;

   typedef logic signed [WordWidth-1:0] wordT;

   typedef logic signed [AccWidth-1:0] accT;

   typedef logic [IndexWidth-1:0] indexT;

   typedef logic [CountWidth-1:0] countT;

   // one beat of a transform stream, last marks position 63
   typedef struct packed
   {
      wordT value;
      logic last;
   } wordBeatT;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the 8x8 IDCT testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module idct2d_tb -f idct2d.f -o simIdct \
   && { ./obj_dir/simIdct > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log; } \
   || { echo "Verilator build failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
   || { echo "simulation finished without failure"; exit 0; }
